// File: access_stage.sv
`timescale 1ns/100ps
`default_nettype none

`include "mem_settings.svh"

module access_stage (
    input  logic                 i_clk,
    input  logic                 i_rst,
    // One strobe per access
    input  logic                 i_valid,
    input  mem_pkg::inst_u       i_inst,
    // Base register and store data
    input  logic [`MEM_XLEN-1:0] i_rs1_rdata,
    input  logic [`MEM_XLEN-1:0] i_rs2_rdata,
    // Request held for one cycle on the memory port
    output mem_pkg::mem_req_s    o_req
);

    logic                  is_load;
    logic                  is_store;
    logic [`MEM_XLEN-1:0]  imm;
    logic [`MEM_XLEN-1:0]  ea;
    logic [1:0]            offset;
    mem_pkg::access_size_e size;
    logic                  is_unsigned;
    logic                  trap;
    logic [`MEM_LANES-1:0] mask;
    logic [`MEM_XLEN-1:0]  wdata;
    mem_pkg::mem_req_s     req_d;

    //////////////////////////////////////////////////
    // Decode and effective address
    //////////////////////////////////////////////////

    // Opcode sits in the same bits in both views
    assign is_load  = i_inst.i.opcode == `MEM_OPC_LOAD;
    assign is_store = i_inst.i.opcode == `MEM_OPC_STORE;

    // S-type immediate for stores, I-type otherwise
    assign imm = is_store ?
        {{(`MEM_XLEN-12){i_inst.s.imm_hi[6]}}, i_inst.s.imm_hi, i_inst.s.imm_lo} :
        {{(`MEM_XLEN-12){i_inst.i.imm[11]}}, i_inst.i.imm};

    assign ea     = i_rs1_rdata + imm;
    assign offset = ea[1:0];

    // Checker and mapper see the same offset and size
    align_checker u_align_checker (
        .i_is_load  (is_load),
        .i_is_store (is_store),
        .i_funct3   (i_inst.i.funct3),
        .i_offset   (offset),
        .o_size     (size),
        .o_unsigned (is_unsigned),
        .o_trap     (trap)
    );

    lane_mapper u_lane_mapper (
        .i_size       (size),
        .i_offset     (offset),
        .i_store_data (i_rs2_rdata),
        .o_mask       (mask),
        .o_wdata      (wdata)
    );

    //////////////////////////////////////////////////
    // Request register
    //////////////////////////////////////////////////

    always_comb begin
        req_d             = '0;
        req_d.addr        = {ea[`MEM_XLEN-1:2], 2'b00};
        req_d.mask        = mask;
        req_d.wdata       = wdata;
        // A trap keeps both enables low
        req_d.ren         = i_valid && is_load && !trap;
        req_d.wen         = i_valid && is_store && !trap;
        req_d.offset      = offset;
        req_d.size        = size;
        req_d.is_unsigned = is_unsigned;
        // Only a good load writes rd
        req_d.rd          = (is_load && !trap) ? i_inst.i.rd : '0;
        req_d.valid       = i_valid;
        req_d.trap        = i_valid && trap;
    end

    always_ff @(posedge i_clk) begin
        o_req <= req_d;
        if (i_rst) begin
            o_req.valid <= 1'b0;
            o_req.ren   <= 1'b0;
            o_req.wen   <= 1'b0;
            o_req.trap  <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: align_checker.sv
`timescale 1ns/100ps
`default_nettype none

module align_checker (
    input  logic                  i_is_load,
    input  logic                  i_is_store,
    input  logic [2:0]            i_funct3,
    input  logic [1:0]            i_offset,
    output mem_pkg::access_size_e o_size,
    output logic                  o_unsigned,
    output logic                  o_trap
);

    logic funct3_ok;
    logic misaligned;

    // Width from funct3[1:0], code 3 falls back to word
    always_comb begin
        case (i_funct3[1:0])
            2'b00:   o_size = mem_pkg::SIZE_BYTE;
            2'b01:   o_size = mem_pkg::SIZE_HALF;
            default: o_size = mem_pkg::SIZE_WORD;
        endcase
    end

    // lbu and lhu set funct3[2]
    assign o_unsigned = i_funct3[2];

    // Loads define 0,1,2,4,5 and stores define 0,1,2
    assign funct3_ok = i_is_load  ? (i_funct3[1:0] != 2'b11 && i_funct3 != 3'b110) :
                       i_is_store ? (i_funct3[2] == 1'b0 && i_funct3[1:0] != 2'b11) :
                                    1'b0;

    // Half needs an even offset, word needs offset zero
    assign misaligned = (o_size == mem_pkg::SIZE_HALF && i_offset[0]) ||
                        (o_size == mem_pkg::SIZE_WORD && i_offset != 2'b00);

    assign o_trap = !funct3_ok || misaligned;

endmodule

`default_nettype wire

// File: files.f
+incdir+.
mem_pkg.sv
lane_mapper.sv
align_checker.sv
access_stage.sv
load_retire.sv
mem_pipe.sv
mem_pipe_checker.sv
tb_mem_pipe.sv

// File: lane_mapper.sv
`timescale 1ns/100ps
`default_nettype none

`include "mem_settings.svh"

module lane_mapper (
    // Access width from the checker
    input  mem_pkg::access_size_e  i_size,
    // Low address bits of the effective address
    input  logic [1:0]             i_offset,
    // Unshifted rs2 value
    input  logic [`MEM_XLEN-1:0]   i_store_data,
    // Byte enables for the aligned word
    output logic [`MEM_LANES-1:0]  o_mask,
    // Store data moved into its lanes
    output logic [`MEM_XLEN-1:0]   o_wdata
);

    //////////////////////////////////////////////////
    // Lane selection
    //////////////////////////////////////////////////

    always_comb begin
        case (i_size)
            mem_pkg::SIZE_BYTE: begin
                // One lane at the byte offset
                o_mask  = 4'b0001 << i_offset;
                o_wdata = i_store_data << {i_offset, 3'b000};
            end
            mem_pkg::SIZE_HALF: begin
                // Low or high pair, picked by offset[1]
                o_mask  = i_offset[1] ? 4'b1100 : 4'b0011;
                o_wdata = i_store_data << {i_offset[1], 4'b0000};
            end
            default: begin
                // Full word, no shift
                o_mask  = 4'b1111;
                o_wdata = i_store_data;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: load_retire.sv
`timescale 1ns/100ps
`default_nettype none

`include "mem_settings.svh"

module load_retire (
    input  logic                 i_clk,
    input  logic                 i_rst,
    // Request currently on the memory port
    input  mem_pkg::mem_req_s    i_req,
    // Read data, one cycle after ren
    input  logic [`MEM_XLEN-1:0] i_dmem_rdata,
    output mem_pkg::retire_s     o_retire
);

    mem_pkg::mem_req_s    req_q;
    logic [7:0]           load_byte;
    logic [15:0]          load_half;
    logic [`MEM_XLEN-1:0] load_ext;

    //////////////////////////////////////////////////
    // Writeback register
    //////////////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        req_q <= i_req;
        if (i_rst) begin
            req_q.valid <= 1'b0;
            req_q.ren   <= 1'b0;
            req_q.wen   <= 1'b0;
            req_q.trap  <= 1'b0;
        end
    end

    //////////////////////////////////////////////////
    // Load extraction
    //////////////////////////////////////////////////

    // Addressed byte and half from the returned word
    assign load_byte = i_dmem_rdata[{req_q.offset, 3'b000} +: 8];
    assign load_half = req_q.offset[1] ? i_dmem_rdata[31:16] : i_dmem_rdata[15:0];

    // Sign or zero fill by the unsigned flag
    always_comb begin
        case (req_q.size)
            mem_pkg::SIZE_BYTE:
                load_ext = {{(`MEM_XLEN-8){load_byte[7] & !req_q.is_unsigned}}, load_byte};
            mem_pkg::SIZE_HALF:
                load_ext = {{(`MEM_XLEN-16){load_half[15] & !req_q.is_unsigned}}, load_half};
            default:
                load_ext = i_dmem_rdata;
        endcase
    end

    //////////////////////////////////////////////////
    // Retire record
    //////////////////////////////////////////////////

    always_comb begin
        o_retire.valid    = req_q.valid;
        o_retire.trap     = req_q.trap;
        o_retire.rd       = req_q.rd;
        // Stores and traps write zero
        o_retire.rd_wdata = req_q.ren ? load_ext : '0;
        // Mirror of the port one cycle back
        o_retire.addr     = req_q.addr;
        o_retire.mask     = req_q.mask;
        o_retire.ren      = req_q.ren;
        o_retire.wen      = req_q.wen;
        o_retire.wdata    = req_q.wdata;
        // Raw word as the memory returned it
        o_retire.rdata    = i_dmem_rdata;
    end

endmodule

`default_nettype wire

// File: mem_pipe.sv
`timescale 1ns/100ps
`default_nettype none

`include "mem_settings.svh"

module mem_pipe (
    input  logic                  i_clk,
    input  logic                  i_rst,
    // Decoded access from the execute side
    input  logic                  i_valid,
    input  mem_pkg::inst_u        i_inst,
    input  logic [`MEM_XLEN-1:0]  i_rs1_rdata,
    input  logic [`MEM_XLEN-1:0]  i_rs2_rdata,
    // Synchronous data memory
    input  logic [`MEM_XLEN-1:0]  i_dmem_rdata,
    output logic [`MEM_XLEN-1:0]  o_dmem_addr,
    output logic                  o_dmem_ren,
    output logic                  o_dmem_wen,
    output logic [`MEM_LANES-1:0] o_dmem_mask,
    output logic [`MEM_XLEN-1:0]  o_dmem_wdata,
    // Two edges after the strobe
    output mem_pkg::retire_s      o_retire
);

    mem_pkg::mem_req_s req;

    access_stage u_access_stage (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_valid     (i_valid),
        .i_inst      (i_inst),
        .i_rs1_rdata (i_rs1_rdata),
        .i_rs2_rdata (i_rs2_rdata),
        .o_req       (req)
    );

    // Memory port comes straight off the request register
    assign o_dmem_addr  = req.addr;
    assign o_dmem_ren   = req.ren;
    assign o_dmem_wen   = req.wen;
    assign o_dmem_mask  = req.mask;
    assign o_dmem_wdata = req.wdata;

    load_retire u_load_retire (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_req        (req),
        .i_dmem_rdata (i_dmem_rdata),
        .o_retire     (o_retire)
    );

endmodule

`default_nettype wire

// File: mem_pipe_checker.sv
`timescale 1ns/100ps
`default_nettype none

`include "mem_settings.svh"

module mem_pipe_checker (
    input logic                  i_clk,
    input logic                  i_rst,
    // Memory port as driven by the DUT
    input logic [`MEM_XLEN-1:0]  i_addr,
    input logic                  i_ren,
    input logic                  i_wen,
    input logic [`MEM_LANES-1:0] i_mask
);

    //////////////////////////////////////////////////
    // Port protocol
    //////////////////////////////////////////////////

    // One access kind per cycle
    a_one_enable: assert property (@(posedge i_clk) disable iff (i_rst) !(i_ren && i_wen))
        else $error("Read and write enables are high in the same cycle");

    // An edge taken in reset leaves the port idle
    a_reset_idle: assert property (@(posedge i_clk) $past(i_rst) |-> (!i_ren && !i_wen))
        else $error("Memory enable high after a reset edge");

    // Port is word addressed
    a_word_addr: assert property (@(posedge i_clk) disable iff (i_rst) i_addr[1:0] == 2'b00)
        else $error("Memory address is not word aligned");

    // Every access touches at least one lane
    a_mask_set: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_ren || i_wen) |-> (i_mask != '0))
        else $error("Memory enable high with an empty byte mask");

endmodule

`default_nettype wire

// File: mem_pkg.sv
`include "mem_settings.svh"

package mem_pkg;

    //////////////////////////////////////////////////
    // Instruction word views
    //////////////////////////////////////////////////

    // I-type layout, used by loads
    typedef struct packed {
        logic [11:0]            imm;
        logic [`MEM_REG_AW-1:0] rs1;
        logic [2:0]             funct3;
        logic [`MEM_REG_AW-1:0] rd;
        logic [6:0]             opcode;
    } inst_i_s;

    // S-type layout, used by stores
    // Immediate is split around rs2/rs1/funct3
    typedef struct packed {
        logic [6:0]             imm_hi;
        logic [`MEM_REG_AW-1:0] rs2;
        logic [`MEM_REG_AW-1:0] rs1;
        logic [2:0]             funct3;
        logic [4:0]             imm_lo;
        logic [6:0]             opcode;
    } inst_s_s;

    // One 32-bit word, read either way
    typedef union packed {
        inst_i_s i;
        inst_s_s s;
    } inst_u;

    // Access width taken from funct3[1:0]
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } access_size_e;

    //////////////////////////////////////////////////
    // Stage records
    //////////////////////////////////////////////////

    // Registered request at the end of the access stage
    typedef struct packed {
        logic [`MEM_XLEN-1:0]          addr;
        logic [`MEM_LANES-1:0]         mask;
        logic [`MEM_XLEN-1:0]          wdata;
        logic                          ren;
        logic                          wen;
        logic [$clog2(`MEM_LANES)-1:0] offset;
        access_size_e                  size;
        logic                          is_unsigned;
        logic [`MEM_REG_AW-1:0]        rd;
        logic                          valid;
        logic                          trap;
    } mem_req_s;

    // Writeback-style retire record
    typedef struct packed {
        logic                  valid;
        logic                  trap;
        logic [`MEM_REG_AW-1:0] rd;
        logic [`MEM_XLEN-1:0]  rd_wdata;
        logic [`MEM_XLEN-1:0]  addr;
        logic [`MEM_LANES-1:0] mask;
        logic                  ren;
        logic                  wen;
        logic [`MEM_XLEN-1:0]  wdata;
        logic [`MEM_XLEN-1:0]  rdata;
    } retire_s;

endpackage

// File: mem_settings.svh
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

//////////////////////////////////////////////////
// Datapath widths
//////////////////////////////////////////////////

// Data and address width of the hart
`define MEM_XLEN 32

// Register-file address width
`define MEM_REG_AW 5

// Byte lanes per data-memory word
`define MEM_LANES 4

// Major opcodes handled by the access stage
`define MEM_OPC_LOAD 7'b0000011
`define MEM_OPC_STORE 7'b0100011

`endif

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_mem_pipe -f files.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_mem_pipe)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# Pass only when the testbench printed its pass line
if printf '%s\n' "$out" | grep -qx "Test OK"; then
    exit 0
fi
exit 1

// File: tb_mem_pipe.sv
`timescale 1ns/100ps
`default_nettype none

`include "mem_settings.svh"

module tb_mem_pipe;

    localparam int HALF_PERIOD   = 20;
    localparam int DRAIN_TIMEOUT = 10;

    // lw x1, 0(x0) and sw x2, 0(x0), both legal and aligned
    localparam logic [31:0] RESET_LOAD  = {12'd0, 5'd0, 3'b010, 5'd1, `MEM_OPC_LOAD};
    localparam logic [31:0] RESET_STORE = {7'd0, 5'd2, 5'd0, 3'b010, 5'd0, `MEM_OPC_STORE};

    logic                  i_clk;
    logic                  i_rst;
    logic                  i_valid;
    mem_pkg::inst_u        i_inst;
    logic [`MEM_XLEN-1:0]  i_rs1_rdata;
    logic [`MEM_XLEN-1:0]  i_rs2_rdata;
    logic [`MEM_XLEN-1:0]  i_dmem_rdata = '0;
    logic [`MEM_XLEN-1:0]  o_dmem_addr;
    logic                  o_dmem_ren;
    logic                  o_dmem_wen;
    logic [`MEM_LANES-1:0] o_dmem_mask;
    logic [`MEM_XLEN-1:0]  o_dmem_wdata;
    mem_pkg::retire_s      o_retire;

    // Memory behind the DUT port and its reference copy
    logic [31:0] mem [0:63];
    logic [31:0] ref_mem [0:63];
    // Last word the reference expects on the read bus
    logic [31:0] ref_rdata;
    logic [31:0] rng;
    int          cyc = 0;
    int          value_errors = 0;
    int          other_errors = 0;
    int          waited;

    // Expected port and retire items with the cycle each is due
    mem_pkg::mem_req_s port_q[$];
    int                port_due_q[$];
    string             port_name_q[$];
    mem_pkg::retire_s  ret_q[$];
    int                ret_due_q[$];
    string             ret_name_q[$];

    mem_pipe i_mem_pipe (.*);

    bind mem_pipe mem_pipe_checker u_mem_pipe_checker (
        .i_clk  (i_clk),
        .i_rst  (i_rst),
        .i_addr (o_dmem_addr),
        .i_ren  (o_dmem_ren),
        .i_wen  (o_dmem_wen),
        .i_mask (o_dmem_mask)
    );

    initial begin
        i_clk = 1'b0;
        forever #HALF_PERIOD i_clk = ~i_clk;
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    function logic [31:0] rand32();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // Power-on contents hashed from the word index
    function automatic logic [31:0] fill_word(input logic [5:0] idx);
        return ({26'd0, idx} * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
    endfunction

    function automatic logic [31:0] merge_lanes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  mask);
        logic [31:0] w;
        w = old_word;
        for (int b = 0; b < 4; b++) begin
            if (mask[b])
                w[8*b +: 8] = new_word[8*b +: 8];
        end
        return w;
    endfunction

    // Synchronous memory where write and read both land at the edge
    always @(posedge i_clk) begin
        cyc <= cyc + 1;
        if (o_dmem_wen)
            mem[o_dmem_addr[7:2]] <= merge_lanes(mem[o_dmem_addr[7:2]], o_dmem_wdata, o_dmem_mask);
        if (o_dmem_ren)
            i_dmem_rdata <= mem[o_dmem_addr[7:2]];
    end

    //////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////

    task automatic check_port(input string name, input mem_pkg::mem_req_s exp,
                              input mem_pkg::mem_req_s act);
        // Lane fields are free while both enables are low
        if (!exp.ren && !exp.wen) begin
            exp.addr  = '0;
            exp.mask  = '0;
            exp.wdata = '0;
            act.addr  = '0;
            act.mask  = '0;
            act.wdata = '0;
        end
        if (act !== exp) begin
            value_errors++;
            $display("[ERROR] %s port: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_retire(input string name, input mem_pkg::retire_s exp,
                                input mem_pkg::retire_s act);
        if (!exp.ren && !exp.wen) begin
            exp.addr  = '0;
            exp.mask  = '0;
            exp.wdata = '0;
            act.addr  = '0;
            act.mask  = '0;
            act.wdata = '0;
        end
        if (act !== exp) begin
            value_errors++;
            $display("[ERROR] %s retire: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            value_errors++;
            $display("[ERROR] %s: expected %h actual %h", name, exp, act);
        end
    endtask

    // Called at each falling edge where outputs are settled
    task automatic check_cycle();
        mem_pkg::mem_req_s act_port;
        act_port       = '0;
        act_port.addr  = o_dmem_addr;
        act_port.mask  = o_dmem_mask;
        act_port.wdata = o_dmem_wdata;
        act_port.ren   = o_dmem_ren;
        act_port.wen   = o_dmem_wen;
        if (port_due_q.size() > 0 && port_due_q[0] == cyc) begin
            check_port(port_name_q[0], port_q[0], act_port);
            void'(port_due_q.pop_front());
            void'(port_name_q.pop_front());
            void'(port_q.pop_front());
        end else if (o_dmem_ren || o_dmem_wen) begin
            other_errors++;
            $display("Memory enable high in cycle %0d with no access due", cyc);
        end
        if (ret_due_q.size() > 0 && ret_due_q[0] == cyc) begin
            check_retire(ret_name_q[0], ret_q[0], o_retire);
            void'(ret_due_q.pop_front());
            void'(ret_name_q.pop_front());
            void'(ret_q.pop_front());
        end else if (o_retire.valid) begin
            other_errors++;
            $display("Retire record valid in cycle %0d with no access due", cyc);
        end
    endtask

    //////////////////////////////////////////////////
    // Stimulus and reference model
    //////////////////////////////////////////////////

    // Mode 0 gives aligned stores and mode 1 aligned loads
    // Mode 2 also allows traps and other opcodes
    task automatic drive_access(input string name, input int mode, input logic valid);
        logic [31:0]       r;
        logic [31:0]       base;
        logic [31:0]       data;
        logic [31:0]       ea;
        logic [31:0]       word;
        logic [31:0]       ext;
        logic [31:0]       wdata;
        logic [11:0]       imm12;
        logic [7:0]        byte_v;
        logic [15:0]       half_v;
        logic [6:0]        opcode;
        logic [4:0]        rd;
        logic [4:0]        rs1;
        logic [4:0]        rs2;
        logic [3:0]        mask;
        logic [2:0]        funct3;
        logic [1:0]        off;
        logic              is_load;
        logic              is_store;
        logic              trap;
        mem_pkg::mem_req_s exp_port;
        mem_pkg::retire_s  exp_ret;
        r = rand32();
        if (mode == 0)
            opcode = `MEM_OPC_STORE;
        else if (mode == 1)
            opcode = `MEM_OPC_LOAD;
        else if (r[2:0] == 3'd6)
            opcode = 7'b0110011;
        else
            opcode = r[0] ? `MEM_OPC_LOAD : `MEM_OPC_STORE;
        funct3 = r[10:8];
        // Fold into the defined codes for the aligned modes
        if (mode != 2 && funct3[1:0] == 2'd3)
            funct3[1:0] = 2'd2;
        if (mode == 0)
            funct3[2] = 1'b0;
        if (mode == 1 && funct3 == 3'd6)
            funct3 = 3'd4;
        r     = rand32();
        rd    = r[4:0];
        rs1   = r[9:5];
        rs2   = r[14:10];
        imm12 = r[31:20];
        base  = {24'd0, r[19:12]};
        if (mode != 2) begin
            imm12[1:0] = 2'b00;
            if (funct3[1:0] == 2'd1)
                base[0] = 1'b0;
            if (funct3[1])
                base[1:0] = 2'b00;
        end
        data = rand32();

        // RISC-V field order for S-type and I-type
        i_valid     = valid;
        i_rs1_rdata = base;
        i_rs2_rdata = data;
        if (opcode == `MEM_OPC_STORE)
            i_inst = {imm12[11:5], rs2, rs1, funct3, imm12[4:0], opcode};
        else
            i_inst = {imm12, rs1, funct3, rd, opcode};
        if (!valid)
            return;

        is_load  = opcode == `MEM_OPC_LOAD;
        is_store = opcode == `MEM_OPC_STORE;
        ea       = base + {{20{imm12[11]}}, imm12};
        off      = ea[1:0];
        trap     = is_load ? !(funct3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5}) :
                   is_store ? !(funct3 inside {3'd0, 3'd1, 3'd2}) : 1'b1;
        trap     = trap || (funct3[1:0] == 2'd1 && off[0]) ||
                   (funct3[1:0] == 2'd2 && off != 2'd0);
        case (funct3[1:0])
            2'd0: begin
                mask  = 4'b0001 << off;
                wdata = data << (8 * off);
            end
            2'd1: begin
                mask  = off[1] ? 4'b1100 : 4'b0011;
                wdata = off[1] ? {data[15:0], 16'h0000} : data;
            end
            default: begin
                mask  = 4'b1111;
                wdata = data;
            end
        endcase

        exp_port       = '0;
        exp_port.addr  = {ea[31:2], 2'b00};
        exp_port.mask  = mask;
        exp_port.wdata = wdata;
        exp_port.ren   = is_load && !trap;
        exp_port.wen   = is_store && !trap;

        // Reference memory sees the access in program order
        ext  = '0;
        word = ref_mem[ea[7:2]];
        if (exp_port.wen)
            ref_mem[ea[7:2]] = merge_lanes(word, wdata, mask);
        if (exp_port.ren) begin
            ref_rdata = word;
            byte_v    = word[8*off +: 8];
            half_v    = off[1] ? word[31:16] : word[15:0];
            if (funct3[1:0] == 2'd0)
                ext = funct3[2] ? {24'd0, byte_v} : {{24{byte_v[7]}}, byte_v};
            else if (funct3[1:0] == 2'd1)
                ext = funct3[2] ? {16'd0, half_v} : {{16{half_v[15]}}, half_v};
            else
                ext = word;
        end

        exp_ret          = '0;
        exp_ret.valid    = 1'b1;
        exp_ret.trap     = trap;
        exp_ret.rd       = exp_port.ren ? rd : 5'd0;
        exp_ret.rd_wdata = ext;
        exp_ret.addr     = exp_port.addr;
        exp_ret.mask     = mask;
        exp_ret.ren      = exp_port.ren;
        exp_ret.wen      = exp_port.wen;
        exp_ret.wdata    = wdata;
        exp_ret.rdata    = ref_rdata;
        port_q.push_back(exp_port);
        port_due_q.push_back(cyc + 1);
        port_name_q.push_back(name);
        ret_q.push_back(exp_ret);
        ret_due_q.push_back(cyc + 2);
        ret_name_q.push_back(name);
    endtask

    // Mode 3 picks one of the others per access
    task automatic run_phase(input string name, input int mode, input int count,
                             input logic gaps);
        logic [31:0] r;
        int          m;
        for (int n = 0; n < count; n++) begin
            @(negedge i_clk);
            check_cycle();
            r = rand32();
            m = mode;
            if (mode == 3)
                m = (r[9:8] == 2'd3) ? 2 : int'(r[9:8]);
            drive_access(name, m, !gaps || r[1:0] != 2'b00);
        end
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial begin
        i_rst       = 1'b1;
        // Legal accesses stay on the inputs while reset is held
        i_valid     = 1'b1;
        i_inst      = RESET_LOAD;
        i_rs1_rdata = '0;
        i_rs2_rdata = '0;
        ref_rdata   = '0;
        rng         = 32'ha17ddac9;
        for (int i = 0; i < 64; i++) begin
            mem[i]     = fill_word(6'(i));
            ref_mem[i] = fill_word(6'(i));
        end
        // Alternate load and store so both enables see the reset
        for (int i = 0; i < 16; i++) begin
            @(posedge i_clk);
            @(negedge i_clk);
            i_inst = i[0] ? RESET_LOAD : RESET_STORE;
        end
        i_valid = 1'b0;
        i_rst   = 1'b0;

        run_phase("store_lanes", 0, 80, 1'b1);
        run_phase("load_extend", 1, 120, 1'b1);
        run_phase("trap_mix", 2, 100, 1'b1);
        run_phase("stream", 3, 300, 1'b0);

        // Let the last two accesses retire
        @(negedge i_clk);
        check_cycle();
        i_valid = 1'b0;
        waited  = 0;
        while (ret_q.size() > 0 && waited < DRAIN_TIMEOUT) begin
            @(negedge i_clk);
            check_cycle();
            waited++;
        end
        if (ret_q.size() > 0) begin
            other_errors++;
            $display("Timed out with %0d retire records still pending", ret_q.size());
        end

        for (int i = 0; i < 64; i++)
            check_word($sformatf("memory[%0d]", i), ref_mem[i], mem[i]);

        $display("Summary: %0d value errors, %0d other errors", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
